// ==== cnn_consts.svh ====
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// ============================================================
// Image geometry and memory
// ============================================================
`define CNN_IMG_DIM       64
`define CNN_PIX_W         8
`define CNN_MEM_DEPTH     1024
`define CNN_ADDR_W        10
// Row in high six bits, column in low six
`define CNN_OUT_ADDR_W    12

// ============================================================
// Code 128-C mark
// ============================================================
`define CNN_CODE_W        11
`define CNN_STOP_W        13
// Start, three symbols, stop
`define CNN_MARK_W        57
`define CNN_MARK_ROWS     10
`define CNN_START_CODE    11'b110_1001_1100
`define CNN_ONE_CODE      11'b110_0110_1100
`define CNN_TWO_CODE      11'b110_0110_0110
`define CNN_THREE_CODE    11'b100_1001_1000
`define CNN_STOP_CODE     13'b1_1000_1110_1011

// ============================================================
// Arithmetic and weight load
// ============================================================
`define CNN_ROUND_BIAS    64
`define CNN_ROUND_SHIFT   7
`define CNN_WEIGHT_WORDS  3

`endif

// ==== cnn_pkg.sv ====
`default_nettype none

`include "cnn_consts.svh"

package cnn_pkg;

	// Wishbone classic master request
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`CNN_ADDR_W-1:0] adr;
		logic [31:0]            dat;
	} wb_req_t;

	// Wishbone classic slave response
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// Barcode result, valid is a one-cycle strobe at scan end
	typedef struct packed {
		logic       valid;
		logic [1:0] ker;
		logic [1:0] str;
		logic [1:0] dil;
	} conv_cfg_t;

	// One convolution result
	typedef struct packed {
		logic [`CNN_PIX_W-1:0]      data;
		logic [`CNN_OUT_ADDR_W-1:0] addr;
	} conv_out_t;

	// Nine weights, element 0 is the top-left tap
	typedef logic [8:0][`CNN_PIX_W-1:0] weights_t;

endpackage

`default_nettype wire

// ==== image_mem.sv ====
`default_nettype none

`include "cnn_consts.svh"

module image_mem
	import cnn_pkg::*;
(
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	input  wire wb_req_t i_req,
	output wb_rsp_t      o_rsp
);

	logic [31:0] mem_q [`CNN_MEM_DEPTH];
	logic [31:0] rdata_q;
	logic        ack_q;
	logic        access;

	// One access per strobe, the ack cycle itself is not a new access
	assign access = i_req.cyc & i_req.stb & ~ack_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// Read data lands together with ack
	always_ff @(posedge i_clk) begin
		if (access) begin
			if (i_req.we) begin
				mem_q[i_req.adr] <= i_req.dat;
			end
			rdata_q <= mem_q[i_req.adr];
		end
	end

	assign o_rsp = '{ack: ack_q, dat: rdata_q};

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`default_nettype none

module mem_arbiter
	import cnn_pkg::*;
#(
	parameter type T_REQ = wb_req_t
) (
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	input  wire T_REQ    i_req_ld,
	input  wire T_REQ    i_req_cv,
	input  wire T_REQ    i_req_bc,
	output wb_rsp_t      o_rsp_ld,
	output wb_rsp_t      o_rsp_cv,
	output wb_rsp_t      o_rsp_bc,
	output T_REQ         o_req_mem,
	input  wire wb_rsp_t i_rsp_mem
);

	localparam logic [1:0] G_NONE = 2'd0;
	localparam logic [1:0] G_LD   = 2'd1;
	localparam logic [1:0] G_CV   = 2'd2;
	localparam logic [1:0] G_BC   = 2'd3;

	logic [1:0] gnt_q;
	logic [1:0] gnt;
	logic       hold;

	// ============================================================
	// Grant selection
	// ============================================================
	always_comb begin
		// Current owner keeps the bus while its cycle lasts
		case (gnt_q)
			G_LD:    hold = i_req_ld.cyc;
			G_CV:    hold = i_req_cv.cyc;
			G_BC:    hold = i_req_bc.cyc;
			default: hold = 1'b0;
		endcase
		// Fixed priority: loader, conv engine, barcode reader
		if (hold) begin
			gnt = gnt_q;
		end else if (i_req_ld.cyc) begin
			gnt = G_LD;
		end else if (i_req_cv.cyc) begin
			gnt = G_CV;
		end else if (i_req_bc.cyc) begin
			gnt = G_BC;
		end else begin
			gnt = G_NONE;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			gnt_q <= G_NONE;
		end else begin
			gnt_q <= gnt;
		end
	end

	// ============================================================
	// Request mux and response routing
	// ============================================================
	always_comb begin
		case (gnt)
			G_LD:    o_req_mem = i_req_ld;
			G_CV:    o_req_mem = i_req_cv;
			G_BC:    o_req_mem = i_req_bc;
			default: o_req_mem = '0;
		endcase
	end

	// Only the owner sees ack
	assign o_rsp_ld = (gnt == G_LD) ? i_rsp_mem : '0;
	assign o_rsp_cv = (gnt == G_CV) ? i_rsp_mem : '0;
	assign o_rsp_bc = (gnt == G_BC) ? i_rsp_mem : '0;

endmodule

`default_nettype wire

// ==== img_loader.sv ====
`default_nettype none

`include "cnn_consts.svh"

module img_loader
	import cnn_pkg::*;
(
	input  wire logic        i_clk,
	input  wire logic        i_rst_n,
	input  wire logic        i_in_valid,
	input  wire logic [31:0] i_in_data,
	output logic             o_in_ready,
	output wb_req_t          o_wb,
	input  wire wb_rsp_t     i_wb,
	output logic             o_img_done,
	input  wire conv_cfg_t   i_cfg,
	output weights_t         o_weights,
	output logic             o_w_load_done,
	output logic             o_cfg_bad
);

	typedef enum logic [2:0] {S_START, S_IMG, S_WAIT_CFG, S_WEI, S_DONE} ld_state_t;

	ld_state_t  state_q;
	logic [1:0] wcnt_q;
	logic [3:0] w_base;
	logic       take;

	assign take   = i_in_valid & o_in_ready;
	assign w_base = {wcnt_q, 2'b00};

	// ============================================================
	// Phase FSM
	// ============================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q       <= S_START;
			o_in_ready    <= 1'b0;
			o_wb          <= '0;
			wcnt_q        <= 2'd0;
			o_img_done    <= 1'b0;
			o_w_load_done <= 1'b0;
			o_cfg_bad     <= 1'b0;
		end else begin
			o_img_done    <= 1'b0;
			o_w_load_done <= 1'b0;
			o_cfg_bad     <= 1'b0;
			case (state_q)
				S_START: begin
					o_in_ready <= 1'b1;
					state_q    <= S_IMG;
				end
				S_IMG: begin
					// Accepted word becomes a write, ready drops until its stb cycle
					if (take) begin
						o_wb.cyc   <= 1'b1;
						o_wb.stb   <= 1'b1;
						o_wb.we    <= 1'b1;
						o_wb.dat   <= i_in_data;
						o_in_ready <= 1'b0;
					end else if (i_wb.ack) begin
						o_wb.cyc <= 1'b0;
						o_wb.stb <= 1'b0;
					end
					// Reopen in the ack cycle, except after the last word
					if (o_wb.stb && !i_wb.ack && o_wb.adr != `CNN_ADDR_W'(`CNN_MEM_DEPTH - 1)) begin
						o_in_ready <= 1'b1;
					end
					if (i_wb.ack) begin
						o_wb.adr <= o_wb.adr + 1'b1;
						if (o_wb.adr == `CNN_ADDR_W'(`CNN_MEM_DEPTH - 1)) begin
							o_img_done <= 1'b1;
							state_q    <= S_WAIT_CFG;
						end
					end
				end
				S_WAIT_CFG: begin
					// Zero kernel field marks a rejected barcode
					if (i_cfg.valid) begin
						if (i_cfg.ker != 2'd0) begin
							o_in_ready <= 1'b1;
							state_q    <= S_WEI;
						end else begin
							o_cfg_bad <= 1'b1;
							state_q   <= S_DONE;
						end
					end
				end
				S_WEI: begin
					if (take) begin
						wcnt_q <= wcnt_q + 1'b1;
						if (wcnt_q == 2'(`CNN_WEIGHT_WORDS - 1)) begin
							o_in_ready    <= 1'b0;
							o_w_load_done <= 1'b1;
							state_q       <= S_DONE;
						end
					end
				end
				default: begin
					o_in_ready <= 1'b0;
				end
			endcase
		end
	end

	// Weights in raster tap order, last word carries one in its top byte
	always_ff @(posedge i_clk) begin
		if (state_q == S_WEI && take) begin
			for (int k = 0; k < 4; k++) begin
				if (w_base + 4'(k) < 4'd9) begin
					o_weights[w_base + 4'(k)] <= i_in_data[31 - 8 * k -: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== barcode_reader.sv ====
`default_nettype none

`include "cnn_consts.svh"

module barcode_reader
	import cnn_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_rst_n,
	input  wire logic      i_img_done,
	output wb_req_t        o_wb,
	input  wire wb_rsp_t   i_wb,
	output conv_cfg_t      o_cfg
);

	localparam int N_POS = `CNN_IMG_DIM - `CNN_MARK_W + 1;

	logic [`CNN_IMG_DIM-1:0] row_q;
	logic [`CNN_IMG_DIM-1:0] row_next;
	logic [3:0]              lsb4;
	logic [`CNN_MARK_W-1:0]  win;
	logic                    hit;
	logic [2:0]              hit_col;
	logic [`CNN_MARK_W-1:0]  hit_pat;
	logic [2:0]              cand_col_q;
	logic [`CNN_MARK_W-1:0]  cand_pat_q;
	logic [3:0]              cand_rows_q;
	logic                    rd_ack;
	logic                    row_end;
	logic                    match;
	logic                    mark_done;
	logic [1:0]              sym_k;
	logic [1:0]              sym_s;
	logic [1:0]              sym_d;
	conv_cfg_t               result;

	function automatic logic [1:0] decode_sym(input logic [`CNN_CODE_W-1:0] code);
		case (code)
			`CNN_ONE_CODE:   decode_sym = 2'd1;
			`CNN_TWO_CODE:   decode_sym = 2'd2;
			`CNN_THREE_CODE: decode_sym = 2'd3;
			default:         decode_sym = 2'd0;
		endcase
	endfunction

	// First pixel of the word sits in the top byte
	assign lsb4     = {i_wb.dat[24], i_wb.dat[16], i_wb.dat[8], i_wb.dat[0]};
	assign row_next = {row_q[`CNN_IMG_DIM-5:0], lsb4};
	assign rd_ack   = o_wb.stb & i_wb.ack;
	assign row_end  = rd_ack & (&o_wb.adr[3:0]);

	// ============================================================
	// Mark search over one finished row
	// ============================================================
	always_comb begin
		hit     = 1'b0;
		hit_col = 3'd0;
		hit_pat = '0;
		// Walk right to left so the leftmost column wins
		for (int c = N_POS - 1; c >= 0; c--) begin
			win = row_next[`CNN_IMG_DIM - 1 - c -: `CNN_MARK_W];
			if (win[`CNN_MARK_W-1 -: `CNN_CODE_W] == `CNN_START_CODE &&
				win[`CNN_STOP_W-1:0] == `CNN_STOP_CODE) begin
				hit     = 1'b1;
				hit_col = 3'(c);
				hit_pat = win;
			end
		end
	end

	// Same column and same pattern as the rows above
	assign match     = hit && cand_rows_q != 4'd0 && hit_col == cand_col_q &&
		hit_pat == cand_pat_q;
	assign mark_done = match && cand_rows_q == 4'(`CNN_MARK_ROWS - 1);

	// Symbols follow the start code
	assign sym_k = decode_sym(hit_pat[`CNN_MARK_W - 1 - `CNN_CODE_W -: `CNN_CODE_W]);
	assign sym_s = decode_sym(hit_pat[`CNN_MARK_W - 1 - 2 * `CNN_CODE_W -: `CNN_CODE_W]);
	assign sym_d = decode_sym(hit_pat[`CNN_MARK_W - 1 - 3 * `CNN_CODE_W -: `CNN_CODE_W]);

	always_comb begin
		result = '0;
		result.valid = 1'b1;
		// Only a 3x3 kernel with nonzero stride and dilation is accepted
		if (mark_done && sym_k == 2'd3 && sym_s != 2'd0 && sym_d != 2'd0) begin
			result.ker = sym_k;
			result.str = sym_s;
			result.dil = sym_d;
		end
	end

	// ============================================================
	// Read sequencer and candidate tracking
	// ============================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb        <= '0;
			o_cfg       <= '0;
			cand_col_q  <= 3'd0;
			cand_rows_q <= 4'd0;
		end else begin
			o_cfg.valid <= 1'b0;
			if (i_img_done) begin
				o_wb.cyc    <= 1'b1;
				o_wb.stb    <= 1'b1;
				o_wb.adr    <= '0;
				cand_rows_q <= 4'd0;
			end else if (rd_ack) begin
				o_wb.adr <= o_wb.adr + 1'b1;
				if (row_end) begin
					if (match) begin
						cand_rows_q <= cand_rows_q + 1'b1;
					end else if (hit) begin
						// Restart on the new sighting
						cand_rows_q <= 4'd1;
						cand_col_q  <= hit_col;
					end else begin
						cand_rows_q <= 4'd0;
					end
					// Stop at a complete mark or at the last row
					if (mark_done || &o_wb.adr) begin
						o_wb.cyc <= 1'b0;
						o_wb.stb <= 1'b0;
						o_cfg    <= result;
					end
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd_ack) begin
			row_q <= row_next;
		end
		if (row_end && hit) begin
			cand_pat_q <= hit_pat;
		end
	end

endmodule

`default_nettype wire

// ==== conv_engine.sv ====
`default_nettype none

`include "cnn_consts.svh"

module conv_engine
	import cnn_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_rst_n,
	input  wire conv_cfg_t i_cfg,
	input  wire weights_t  i_weights,
	input  wire logic      i_w_load_done,
	input  wire logic      i_cfg_bad,
	output wb_req_t        o_wb,
	input  wire wb_rsp_t   i_wb,
	output logic           o_out_valid,
	output conv_out_t      o_out,
	output logic           o_exe_finish
);

	typedef enum logic [1:0] {S_IDLE, S_START, S_RUN, S_DONE} cv_state_t;

	cv_state_t             state_q;
	logic [1:0]            str_q;
	logic [1:0]            dil_q;
	weights_t              weights_q;
	logic [5:0]            row_q;
	logic [5:0]            col_q;
	logic [3:0]            tap_q;
	logic signed [19:0]    acc_q;
	logic [7:0]            trow [9];
	logic [7:0]            tcol [9];
	logic [8:0]            pad;
	logic [3:0]            first_tap;
	logic [3:0]            next_tap;
	logic                  has_next;
	logic [1:0]            byte_c;
	logic [`CNN_PIX_W-1:0] pix;
	logic signed [16:0]    prod;
	logic signed [19:0]    mac_sum;
	logic signed [20:0]    rounded;
	logic signed [20:0]    shifted;
	logic [`CNN_PIX_W-1:0] clamp_val;
	logic [6:0]            col_step;
	logic [6:0]            row_step;
	logic                  last_ack;

	// Tap coordinate at offset -D, 0 or +D, out of range shows in the top bits
	function automatic logic [7:0] tap_pos(input logic [5:0] base, input logic [1:0] sel,
		input logic [1:0] d);
		logic [7:0] b;
		b = {2'b00, base};
		case (sel)
			2'd0:    tap_pos = b - {6'b0, d};
			2'd1:    tap_pos = b;
			default: tap_pos = b + {6'b0, d};
		endcase
	endfunction

	// ============================================================
	// Tap geometry for the current position
	// ============================================================
	always_comb begin
		for (int k = 0; k < 9; k++) begin
			trow[k] = tap_pos(row_q, 2'(k / 3), dil_q);
			tcol[k] = tap_pos(col_q, 2'(k % 3), dil_q);
			pad[k]  = (trow[k][7:6] != 2'b00) || (tcol[k][7:6] != 2'b00);
		end
		// Lowest unpadded tap overall and after the current one
		first_tap = 4'd4;
		next_tap  = 4'd0;
		has_next  = 1'b0;
		for (int k = 8; k >= 0; k--) begin
			if (!pad[k]) begin
				first_tap = 4'(k);
				if (4'(k) > tap_q) begin
					next_tap = 4'(k);
					has_next = 1'b1;
				end
			end
		end
	end

	// Word holds four pixels, column 0 in the top byte
	assign o_wb = '{
		cyc: state_q == S_RUN,
		stb: state_q == S_RUN,
		we:  1'b0,
		adr: {trow[tap_q][5:0], tcol[tap_q][5:2]},
		dat: '0
	};

	// ============================================================
	// MAC, rounding and clamp
	// ============================================================
	assign byte_c  = ~tcol[tap_q][1:0];
	assign pix     = i_wb.dat[{byte_c, 3'b000} +: `CNN_PIX_W];
	assign prod    = $signed({1'b0, pix}) * $signed(weights_q[tap_q]);
	assign mac_sum = acc_q + 20'(prod);
	assign rounded = 21'(mac_sum) + signed'(21'(`CNN_ROUND_BIAS));
	assign shifted = rounded >>> `CNN_ROUND_SHIFT;

	always_comb begin
		if (shifted < 0) begin
			clamp_val = '0;
		end else if (shifted > 21'sd255) begin
			clamp_val = '1;
		end else begin
			clamp_val = shifted[`CNN_PIX_W-1:0];
		end
	end

	assign last_ack = (state_q == S_RUN) && i_wb.ack && !has_next;
	assign col_step = {1'b0, col_q} + {5'b0, str_q};
	assign row_step = {1'b0, row_q} + {5'b0, str_q};

	// ============================================================
	// Position walk
	// ============================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q      <= S_IDLE;
			str_q        <= 2'd0;
			dil_q        <= 2'd0;
			row_q        <= 6'd0;
			col_q        <= 6'd0;
			tap_q        <= 4'd0;
			acc_q        <= '0;
			o_out_valid  <= 1'b0;
			o_exe_finish <= 1'b0;
		end else begin
			o_out_valid <= 1'b0;
			if (i_cfg.valid && i_cfg.ker == 2'd3) begin
				str_q <= i_cfg.str;
				dil_q <= i_cfg.dil;
			end
			// Rejected barcode ends the run without outputs
			if (i_cfg_bad) begin
				o_exe_finish <= 1'b1;
			end
			case (state_q)
				S_IDLE: begin
					if (i_w_load_done) begin
						state_q <= S_START;
					end
				end
				S_START: begin
					tap_q   <= first_tap;
					acc_q   <= '0;
					state_q <= S_RUN;
				end
				S_RUN: begin
					if (i_wb.ack) begin
						acc_q <= mac_sum;
						tap_q <= next_tap;
					end
					if (last_ack) begin
						o_out_valid <= 1'b1;
						state_q     <= S_START;
						if (col_step < 7'(`CNN_IMG_DIM)) begin
							col_q <= col_step[5:0];
						end else begin
							col_q <= 6'd0;
							row_q <= row_step[5:0];
							if (row_step >= 7'(`CNN_IMG_DIM)) begin
								state_q <= S_DONE;
							end
						end
					end
				end
				default: begin
					o_exe_finish <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_w_load_done) begin
			weights_q <= i_weights;
		end
		if (last_ack) begin
			o_out.data <= clamp_val;
			o_out.addr <= {row_q, col_q};
		end
	end

endmodule

`default_nettype wire

// ==== cnn_top.sv ====
`default_nettype none

module cnn_top
	import cnn_pkg::*;
(
	input  wire logic        i_clk,
	input  wire logic        i_rst_n,
	input  wire logic        i_in_valid,
	input  wire logic [31:0] i_in_data,
	output logic             o_in_ready,
	output logic             o_cfg_valid,
	output conv_cfg_t        o_cfg,
	output logic             o_out_valid,
	output conv_out_t        o_out,
	output logic             o_exe_finish
);

	// Wishbone links, one per master plus the memory side
	wb_req_t   req_ld;
	wb_req_t   req_cv;
	wb_req_t   req_bc;
	wb_req_t   req_mem;
	wb_rsp_t   rsp_ld;
	wb_rsp_t   rsp_cv;
	wb_rsp_t   rsp_bc;
	wb_rsp_t   rsp_mem;

	// Phase handoff
	logic      img_done;
	logic      w_load_done;
	logic      cfg_bad;
	conv_cfg_t cfg;
	weights_t  weights;

	assign o_cfg       = cfg;
	assign o_cfg_valid = cfg.valid;

	img_loader u_loader (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_in_valid    (i_in_valid),
		.i_in_data     (i_in_data),
		.o_in_ready    (o_in_ready),
		.o_wb          (req_ld),
		.i_wb          (rsp_ld),
		.o_img_done    (img_done),
		.i_cfg         (cfg),
		.o_weights     (weights),
		.o_w_load_done (w_load_done),
		.o_cfg_bad     (cfg_bad)
	);

	barcode_reader u_barcode (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_img_done (img_done),
		.o_wb       (req_bc),
		.i_wb       (rsp_bc),
		.o_cfg      (cfg)
	);

	conv_engine u_conv (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_cfg         (cfg),
		.i_weights     (weights),
		.i_w_load_done (w_load_done),
		.i_cfg_bad     (cfg_bad),
		.o_wb          (req_cv),
		.i_wb          (rsp_cv),
		.o_out_valid   (o_out_valid),
		.o_out         (o_out),
		.o_exe_finish  (o_exe_finish)
	);

	mem_arbiter #(
		.T_REQ (wb_req_t)
	) u_arbiter (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_req_ld  (req_ld),
		.i_req_cv  (req_cv),
		.i_req_bc  (req_bc),
		.o_rsp_ld  (rsp_ld),
		.o_rsp_cv  (rsp_cv),
		.o_rsp_bc  (rsp_bc),
		.o_req_mem (req_mem),
		.i_rsp_mem (rsp_mem)
	);

	image_mem u_mem (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_req   (req_mem),
		.o_rsp   (rsp_mem)
	);

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
	input  wire logic i_rst_req,
	output logic      o_clk,
	output logic      o_rst_n
);

	// Free running clock, period 10
	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// Reset low for two rising edges at start and again on every request
	initial begin
		o_rst_n = 1'b0;
		forever begin
			repeat (2) @(posedge o_clk);
			// Release away from the sampling point
			@(negedge o_clk);
			o_rst_n = 1'b1;
			@(posedge i_rst_req);
			o_rst_n = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== tb_cnn.sv ====
`default_nettype none

`include "cnn_consts.svh"

module tb_cnn
	import cnn_pkg::*;
();

	localparam int DIM     = `CNN_IMG_DIM;
	localparam int WORD_TO = 40;
	localparam int CFG_TO  = 4 * `CNN_MEM_DEPTH + 200;
	localparam int OUT_TO  = 100;

	logic        clk;
	logic        rst_n;
	logic        rst_req;
	logic        in_valid;
	logic [31:0] in_data;
	logic        in_ready;
	logic        cfg_valid;
	conv_cfg_t   cfg;
	logic        out_valid;
	conv_out_t   out;
	logic        exe_finish;

	// Reference image and expected output stream
	logic [7:0]  img [DIM][DIM];
	conv_out_t   exp_q [$];
	integer      seed;
	int          errors;
	int          checks;
	int          tests;
	bit          timed_out;

	// Fields of the current stim line
	int          t_seed;
	int          t_row;
	int          t_col;
	int          t_ks;
	int          t_ss;
	int          t_ds;
	int          t_decoy;
	logic [7:0]  t_w [9];

	tb_clk_gen u_clk_gen (
		.i_rst_req (rst_req),
		.o_clk     (clk),
		.o_rst_n   (rst_n)
	);

	cnn_top i_dut (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_in_valid   (in_valid),
		.i_in_data    (in_data),
		.o_in_ready   (in_ready),
		.o_cfg_valid  (cfg_valid),
		.o_cfg        (cfg),
		.o_out_valid  (out_valid),
		.o_out        (out),
		.o_exe_finish (exe_finish)
	);

	// ============================================================
	// Image and mark construction
	// ============================================================
	function automatic logic [`CNN_CODE_W-1:0] sym_code(input int sel);
		case (sel)
			1:       sym_code = `CNN_ONE_CODE;
			2:       sym_code = `CNN_TWO_CODE;
			default: sym_code = `CNN_THREE_CODE;
		endcase
	endfunction

	task automatic fill_image();
		logic [31:0] v;
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c += 4) begin
				// Every pixel LSB cleared so only the mark sets them
				v = $random(seed) & 32'hFEFE_FEFE;
				for (int b = 0; b < 4; b++) begin
					img[r][c + b] = v[31 - 8 * b -: 8];
				end
			end
		end
	endtask

	// Leftmost column carries the first mark bit
	task automatic paint_mark(input int first, input int rows, input int col,
		input int ks, input int ss, input int ds);
		logic [`CNN_MARK_W-1:0] mark;
		mark = {`CNN_START_CODE, sym_code(ks), sym_code(ss), sym_code(ds), `CNN_STOP_CODE};
		for (int r = first; r < first + rows; r++) begin
			for (int j = 0; j < `CNN_MARK_W; j++) begin
				img[r][col + j][0] = mark[`CNN_MARK_W - 1 - j];
			end
		end
	endtask

	function automatic logic [31:0] image_word(input int i);
		int r;
		int c;
		r = i / 16;
		c = (i % 16) * 4;
		image_word = {img[r][c], img[r][c + 1], img[r][c + 2], img[r][c + 3]};
	endfunction

	// ============================================================
	// Convolution model
	// ============================================================
	function automatic logic [7:0] conv_model(input int r, input int c, input int d);
		int sum;
		int tr;
		int tc;
		int v;
		sum = 0;
		for (int k = 0; k < 9; k++) begin
			tr = r + (k / 3 - 1) * d;
			tc = c + (k % 3 - 1) * d;
			// Padding taps add nothing
			if (tr >= 0 && tr < DIM && tc >= 0 && tc < DIM) begin
				sum += int'(img[tr][tc]) * int'($signed(t_w[k]));
			end
		end
		v = (sum + `CNN_ROUND_BIAS) >>> `CNN_ROUND_SHIFT;
		if (v < 0) begin
			conv_model = 8'd0;
		end else if (v > 255) begin
			conv_model = 8'd255;
		end else begin
			conv_model = 8'(v);
		end
	endfunction

	task automatic build_expected(input int s, input int d, output int lo, output int hi);
		conv_out_t e;
		lo = 0;
		hi = 0;
		for (int r = 0; r < DIM; r += s) begin
			for (int c = 0; c < DIM; c += s) begin
				e.data = conv_model(r, c, d);
				e.addr = 12'(r * DIM + c);
				if (e.data == 8'd0) begin
					lo++;
				end
				if (e.data == 8'hff) begin
					hi++;
				end
				exp_q.push_back(e);
			end
		end
	endtask

	// ============================================================
	// Bus drivers
	// ============================================================
	task automatic reset_dut();
		int n;
		n = 0;
		rst_req = 1'b1;
		@(posedge clk);
		#1;
		rst_req = 1'b0;
		checks++;
		if (in_ready || cfg_valid || out_valid || exe_finish) begin
			$display("outputs not idle while reset is held");
			errors++;
		end
		while (!rst_n && n < 10) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!rst_n) begin
			$display("timeout waiting for reset release");
			timed_out = 1'b1;
			errors++;
		end
	endtask

	// Valid held until ready is seen so the transfer lands on the next edge
	task automatic send_word(input logic [31:0] data, inout int pauses);
		int n;
		n = 0;
		in_valid = 1'b1;
		in_data  = data;
		while (!in_ready && n < WORD_TO) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!in_ready) begin
			$display("timeout waiting for o_in_ready");
			timed_out = 1'b1;
			errors++;
		end
		pauses += n;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("error %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	// ============================================================
	// One test from one stim line
	// ============================================================
	task automatic run_test();
		int pauses;
		int n;
		int idx;
		int lo;
		int hi;
		int err0;
		bit good;
		err0 = errors;
		lo = 0;
		hi = 0;
		idx = 0;
		tests++;
		reset_dut();
		if (timed_out) begin
			return;
		end
		seed = 24494 + t_seed;
		fill_image();
		// Decoy of six rows and a gap, four more rows and then the real mark
		if (t_decoy != 0) begin
			paint_mark(t_row - 11, 6, t_col, 3, 1, 1);
			paint_mark(t_row - 4, 4, t_col, 3, 1, 1);
		end
		paint_mark(t_row, `CNN_MARK_ROWS, t_col, t_ks, t_ss, t_ds);
		pauses = 0;
		for (int i = 0; i < `CNN_MEM_DEPTH; i++) begin
			send_word(image_word(i), pauses);
			if (timed_out) begin
				return;
			end
		end
		checks++;
		if (pauses < `CNN_MEM_DEPTH - 1) begin
			$display("o_in_ready did not pause between image words (%0d pauses)", pauses);
			errors++;
		end
		n = 0;
		while (!cfg_valid && n < CFG_TO) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!cfg_valid) begin
			$display("timeout waiting for o_cfg_valid");
			timed_out = 1'b1;
			errors++;
			return;
		end
		// Only kernel 3 is accepted and a rejected mark zeroes every field
		good = (t_ks == 3);
		check_value("o_cfg.ker", 32'(cfg.ker), good ? 32'(t_ks) : 32'd0);
		check_value("o_cfg.str", 32'(cfg.str), good ? 32'(t_ss) : 32'd0);
		check_value("o_cfg.dil", 32'(cfg.dil), good ? 32'(t_ds) : 32'd0);
		exp_q.delete();
		if (good) begin
			build_expected(t_ss, t_ds, lo, hi);
			// The stride 2 dilation 3 case must reach both clamp limits
			if (t_ss == 2 && t_ds == 3) begin
				checks++;
				if (lo == 0 || hi == 0) begin
					$display("stimulus misses a clamp limit (%0d low, %0d high)", lo, hi);
					errors++;
				end
			end
			send_word({t_w[0], t_w[1], t_w[2], t_w[3]}, pauses);
			send_word({t_w[4], t_w[5], t_w[6], t_w[7]}, pauses);
			send_word({t_w[8], 24'h0}, pauses);
			if (timed_out) begin
				return;
			end
		end
		// Outputs arrive in raster order until finish
		n = 0;
		while (!exe_finish && n < OUT_TO && idx <= exp_q.size()) begin
			@(posedge clk);
			#1;
			n++;
			if (out_valid) begin
				n = 0;
				if (idx < exp_q.size()) begin
					check_value("o_out.data", 32'(out.data), 32'(exp_q[idx].data));
					check_value("o_out.addr", 32'(out.addr), 32'(exp_q[idx].addr));
				end
				idx++;
			end
		end
		if (!exe_finish) begin
			$display("timeout or overrun waiting for o_exe_finish after %0d outputs", idx);
			timed_out = 1'b1;
			errors++;
			return;
		end
		checks++;
		if (idx != exp_q.size()) begin
			$display("expected %0d outputs but received %0d", exp_q.size(), idx);
			errors++;
		end
		$display("test %0d: k=%0d s=%0d d=%0d, %0d outputs, %0d/%0d clamped, %0d errors",
			tests, t_ks, t_ss, t_ds, idx, lo, hi, errors - err0);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		int fd;
		int nf;
		int n;
		string line;
		in_valid  = 1'b0;
		in_data   = 32'd0;
		rst_req   = 1'b0;
		seed      = 24494;
		errors    = 0;
		checks    = 0;
		tests     = 0;
		timed_out = 1'b0;
		n = 0;
		// Power-on reset from the clock generator
		while (!rst_n && n < 10) begin
			@(posedge clk);
			#1;
			n++;
		end
		fd = $fopen("cnn_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open cnn_stim.txt");
			errors++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					nf = $sscanf(line, "%d %d %d %d %d %d %d %h %h %h %h %h %h %h %h %h",
						t_seed, t_row, t_col, t_ks, t_ss, t_ds, t_decoy, t_w[0], t_w[1],
						t_w[2], t_w[3], t_w[4], t_w[5], t_w[6], t_w[7], t_w[8]);
					if (nf == 16) begin
						run_test();
					end else begin
						$display("malformed stim line: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && tests > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== cnn_stim.txt ====
# seed row col ksel ssel dsel decoy w0..w8 (selectors pick code 1..3, weights in hex)
# decoy 1 paints a mark above that breaks after six rows
1 20 3 3 1 1 0 08 10 08 10 20 10 08 10 08
2 40 0 2 1 1 0 10 10 10 10 10 10 10 10 10
3 5 7 3 2 3 0 7f 7f 7f 80 80 80 7f 80 7f
4 30 2 3 3 2 1 f0 1a 05 e3 40 22 fc 11 08
5 54 1 3 2 2 0 81 00 7f 00 01 00 7f 00 81
6 11 4 3 3 3 0 05 fb 05 fb 50 fb 05 fb 05

// ==== compile.f ====
+incdir+.
cnn_pkg.sv
image_mem.sv
mem_arbiter.sv
img_loader.sv
barcode_reader.sv
conv_engine.sv
cnn_top.sv
tb_clk_gen.sv
tb_cnn.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_cnn
FILELIST   := compile.f
OBJDIR     := obj_dir
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
